//--- all.f
hw/heapPkg.sv
hw/arrayStore.sv
hw/arrayAllocator.sv
hw/apbRegs.sv
hw/heapSequencer.sv
hw/heapTop.sv
tests/heapTb.sv

//--- hw/apbRegs.sv
`timescale 1ns/1ps
//------------------------------
// APB3 slave, no wait states except a command write while busy
// Status busy stays set until the response has been captured
//------------------------------
module apbRegs (
  input  logic              clock,
  input  logic              resetN,
  input  heapPkg::apbReqT   apbReq,
  output heapPkg::apbRespT  apbResp,
  output heapPkg::heapCmdT  cmd,
  output logic              start,
  input  logic              busy,
  input  heapPkg::heapRespT resp
);

  heapPkg::arrayIdT arrayQ;                             // Operand registers
  heapPkg::elemIdxT indexQ;
  heapPkg::dataT    dataQ;
  heapPkg::dataT    resultQ;                            // Last result
  heapPkg::errorT   errorQ;                             // Last error
  logic             busyQ;                              // Busy one cycle ago
  logic             access;
  logic             cmdWrite;
  logic             mapped;
  logic             readOnly;

  assign access   = apbReq.psel && apbReq.penable;
  assign cmdWrite = apbReq.psel && apbReq.pwrite && apbReq.paddr == heapPkg::regCommand;
  assign start    = access && cmdWrite && !busy;      // Pulse on the completing edge

  // Opcode comes straight from the command write data
  assign cmd = '{opcode: heapPkg::opcodeT'(apbReq.pwdata[$bits(heapPkg::opcodeT)-1:0]),
                 array:  arrayQ,
                 index:  indexQ,
                 data:   dataQ};

  always_comb begin
    mapped   = 1'b1;
    readOnly = 1'b0;
    apbResp.prdata = '0;                                // Command reads back as zero
    case (apbReq.paddr)
      heapPkg::regArray:   apbResp.prdata = 32'(arrayQ);
      heapPkg::regIndex:   apbResp.prdata = 32'(indexQ);
      heapPkg::regData:    apbResp.prdata = 32'(dataQ);
      heapPkg::regCommand: ;
      heapPkg::regResult: begin
        readOnly       = 1'b1;
        apbResp.prdata = 32'(resultQ);
      end
      heapPkg::regStatus: begin
        readOnly       = 1'b1;
        apbResp.prdata = 32'({errorQ, 3'b000, busy || busyQ});
      end
      default: mapped = 1'b0;
    endcase
    apbResp.pready  = !(cmdWrite && busy);              // Stall until sequencer idle
    apbResp.pslverr = access && (!mapped || (apbReq.pwrite && readOnly));
  end

  // ------------------------------
  // Operands and captured response
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      arrayQ  <= '0;
      indexQ  <= '0;
      dataQ   <= '0;
      resultQ <= '0;
      errorQ  <= heapPkg::none;
      busyQ   <= 1'b0;
    end else begin
      busyQ <= busy;
      if (access && apbReq.pwrite) begin
        case (apbReq.paddr)
          heapPkg::regArray: arrayQ <= apbReq.pwdata[heapPkg::arrayBits-1:0];
          heapPkg::regIndex: indexQ <= apbReq.pwdata[heapPkg::indexBits-1:0];
          heapPkg::regData:  dataQ  <= apbReq.pwdata[heapPkg::dataBits-1:0];
          default: ;                                    // Read only writes are dropped
        endcase
      end
      if (busyQ && !busy) begin                         // Command just ended
        resultQ <= resp.data;
        errorQ  <= resp.error;
      end
    end
  end

endmodule

//--- hw/arrayAllocator.sv
`timescale 1ns/1ps
//------------------------------
// Hands out arrays, freed ones first, then from the high water mark
// Caller must only release allocated arrays
//------------------------------
module arrayAllocator (
  input  logic             clock,
  input  logic             resetN,
  input  logic             allocate,
  input  logic             releaseReq,
  input  logic             clearAll,
  input  heapPkg::arrayIdT array,
  output logic             isAllocated,
  output heapPkg::sizeT    highWater,
  output logic             canAllocate,
  output heapPkg::arrayIdT nextArray
);

  heapPkg::arrayIdT                    freedStack [heapPkg::arrayCount];
  heapPkg::sizeT                       stackTop;        // Entries in freed stack
  heapPkg::sizeT                       highWaterQ;      // Arrays ever handed out
  logic [heapPkg::arrayCount-1:0]      allocFlags;
  logic                                stackEmpty;

  assign stackEmpty  = stackTop == '0;
  assign highWater   = highWaterQ;
  assign isAllocated = allocFlags[array];
  assign nextArray   = stackEmpty ? heapPkg::arrayIdT'(highWaterQ)
                                  : freedStack[heapPkg::arrayIdT'(stackTop - 3'd1)];
  assign canAllocate = !(stackEmpty && highWaterQ == heapPkg::sizeT'(heapPkg::arrayCount));

  always_ff @(posedge clock) begin
    if (releaseReq) freedStack[heapPkg::arrayIdT'(stackTop)] <= array;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      stackTop   <= '0;
      highWaterQ <= '0;
      allocFlags <= '0;
    end else if (clearAll) begin
      stackTop   <= '0;
      highWaterQ <= '0;
      allocFlags <= '0;
    end else if (allocate) begin
      if (stackEmpty) highWaterQ <= highWaterQ + 3'd1;  // Fresh array
      else stackTop <= stackTop - 3'd1;                 // Reuse freed array
      allocFlags[nextArray] <= 1'b1;
    end else if (releaseReq) begin
      stackTop          <= stackTop + 3'd1;
      allocFlags[array] <= 1'b0;                        // Flag of the freed array itself
    end
  end

endmodule

//--- hw/arrayStore.sv
`timescale 1ns/1ps
//------------------------------
// Element storage, reads are combinational
// Sizes reset to zero, contents do not
//------------------------------
module arrayStore (
  input  logic             clock,
  input  logic             resetN,
  input  heapPkg::arrayIdT array,
  input  heapPkg::elemIdxT index,
  input  logic             write,
  input  heapPkg::dataT    data,
  input  logic             sizeWrite,
  input  heapPkg::sizeT    newSize,
  input  logic             clearSizes,
  output heapPkg::dataT    readData,
  output heapPkg::sizeT    arraySize
);

  heapPkg::dataT mem   [heapPkg::arrayCount][heapPkg::arrayLength];  // Fixed blocks
  heapPkg::sizeT sizes [heapPkg::arrayCount];                         // Current sizes

  assign readData  = mem[array][index];
  assign arraySize = sizes[array];

  always_ff @(posedge clock) begin
    if (write) mem[array][index] <= data;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      sizes <= '{default: '0};
    end else if (clearSizes) begin
      sizes <= '{default: '0};                          // Clear command
    end else if (sizeWrite) begin
      sizes[array] <= newSize;
    end
  end

endmodule

//--- hw/heapPkg.sv
//------------------------------
// Sizes, types, opcodes and register map of the array heap
// 4 arrays of 4 elements of 12 bits, reached over APB
//------------------------------
package heapPkg;

  // ------------------------------
  // Sizes
  localparam int arrayBits   = 2;                       // Bits in an array number
  localparam int indexBits   = 2;                       // Bits in an element index
  localparam int dataBits    = 12;                      // Element width
  localparam int arrayCount  = 4;                       // Arrays in the heap
  localparam int arrayLength = 4;                       // Elements per array
  localparam int apbAddrBits = 8;                       // APB address width

  typedef logic [arrayBits-1:0]   arrayIdT;             // Array number
  typedef logic [indexBits-1:0]   elemIdxT;             // Element index
  typedef logic [indexBits:0]     sizeT;                // 0 up to arrayLength
  typedef logic [dataBits-1:0]    dataT;                // Element value
  typedef logic [apbAddrBits-1:0] apbAddrT;             // Register offset

  // ------------------------------
  // Commands and results
  typedef enum logic [4:0] {
    clear        = 5'd1,                                // Free every array
    write        = 5'd2,
    read         = 5'd3,
    size         = 5'd4,
    index        = 5'd7,                                // Last match position + 1
    countLess    = 5'd8,
    countGreater = 5'd9,
    push         = 5'd14,
    pop          = 5'd15,
    alloc        = 5'd18,
    free         = 5'd19
  } opcodeT;

  typedef enum logic [2:0] {
    none         = 3'd0,
    notAllocated = 3'd1,                                // At or above high water
    freed        = 3'd2,                                // Not allocated now
    outOfBounds  = 3'd3,                                // Read past size
    full         = 3'd4,
    empty        = 3'd5,
    outOfMemory  = 3'd6,
    badOpcode    = 3'd7
  } errorT;

  typedef enum logic [1:0] {idle, check, scan, finish} seqStateT;

  typedef struct packed {
    opcodeT  opcode;
    arrayIdT array;
    elemIdxT index;
    dataT    data;
  } heapCmdT;

  typedef struct packed {
    dataT  data;
    errorT error;
  } heapRespT;

  // ------------------------------
  // APB
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    apbAddrT     paddr;
    logic [31:0] pwdata;
  } apbReqT;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apbRespT;

  localparam apbAddrT regArray   = 8'h00;
  localparam apbAddrT regIndex   = 8'h04;
  localparam apbAddrT regData    = 8'h08;
  localparam apbAddrT regCommand = 8'h0C;               // Write only, starts a command
  localparam apbAddrT regResult  = 8'h10;               // Read only
  localparam apbAddrT regStatus  = 8'h14;               // Read only, busy bit 0, error 6:4

endpackage

//--- hw/heapSequencer.sv
`timescale 1ns/1ps
//------------------------------
// Checks and runs one heap command
// 2 cycles per command, searches add one cycle per element
//------------------------------
module heapSequencer (
  input  logic              clock,
  input  logic              resetN,
  input  heapPkg::heapCmdT  cmd,
  input  logic              start,
  output logic              busy,
  output heapPkg::heapRespT resp,
  output heapPkg::arrayIdT  storeArray,
  output heapPkg::elemIdxT  storeIndex,
  output logic              storeWrite,
  output heapPkg::dataT     storeData,
  output logic              sizeWrite,
  output heapPkg::sizeT     newSize,
  output logic              clearSizes,
  input  heapPkg::dataT     readData,
  input  heapPkg::sizeT     arraySize,
  output logic              allocate,
  output logic              releaseReq,
  input  logic              isAllocated,
  input  heapPkg::sizeT     highWater,
  input  logic              canAllocate,
  input  heapPkg::arrayIdT  nextArray
);

  heapPkg::seqStateT state;
  heapPkg::heapCmdT  cmdQ;                              // Command being run
  heapPkg::dataT     resultQ;                           // Kept when a command has no result
  heapPkg::errorT    errorQ;
  heapPkg::elemIdxT  scanIdx;
  heapPkg::sizeT     accum;                             // Search position or count
  heapPkg::sizeT     accumNext;
  heapPkg::errorT    checkError;
  logic              arrayOp;                           // Needs an allocated array
  logic              checkOk;
  logic              inRange;
  logic              lastScan;

  assign busy      = state != heapPkg::idle;
  assign resp      = '{data: resultQ, error: errorQ};
  assign storeData = cmdQ.data;
  assign checkOk   = state == heapPkg::check && checkError == heapPkg::none;
  assign inRange   = {1'b0, scanIdx} < arraySize;
  assign lastScan  = scanIdx == heapPkg::elemIdxT'(heapPkg::arrayLength - 1);
  assign arrayOp   = !(cmdQ.opcode inside {heapPkg::clear, heapPkg::alloc});

  // ------------------------------
  // Error rules, first match wins
  always_comb begin
    checkError = heapPkg::none;
    if (arrayOp && {1'b0, cmdQ.array} >= highWater) begin
      checkError = heapPkg::notAllocated;
    end else if (arrayOp && !isAllocated) begin
      checkError = heapPkg::freed;                      // Also catches a double free
    end else begin
      case (cmdQ.opcode)
        heapPkg::alloc: if (!canAllocate) checkError = heapPkg::outOfMemory;
        heapPkg::read:  if ({1'b0, cmdQ.index} >= arraySize) checkError = heapPkg::outOfBounds;
        heapPkg::push:  if (arraySize == heapPkg::sizeT'(heapPkg::arrayLength)) checkError = heapPkg::full;
        heapPkg::pop:   if (arraySize == '0) checkError = heapPkg::empty;
        heapPkg::clear, heapPkg::free, heapPkg::write, heapPkg::size,
        heapPkg::index, heapPkg::countLess, heapPkg::countGreater: ;
        default: checkError = heapPkg::badOpcode;
      endcase
    end
  end

  // Store and allocator controls, effects only in a clean check
  always_comb begin
    storeArray = cmdQ.opcode == heapPkg::alloc ? nextArray : cmdQ.array;
    storeIndex = cmdQ.index;
    storeWrite = 1'b0;
    sizeWrite  = 1'b0;
    newSize    = '0;                                    // Alloc empties the array
    allocate   = 1'b0;
    releaseReq = 1'b0;
    clearSizes = 1'b0;
    case (cmdQ.opcode)
      heapPkg::push: storeIndex = heapPkg::elemIdxT'(arraySize);
      heapPkg::pop:  storeIndex = heapPkg::elemIdxT'(arraySize - 3'd1);
      default: if (state == heapPkg::scan) storeIndex = scanIdx;
    endcase
    if (checkOk) begin
      case (cmdQ.opcode)
        heapPkg::clear: clearSizes = 1'b1;
        heapPkg::alloc: begin
          allocate  = 1'b1;
          sizeWrite = 1'b1;
        end
        heapPkg::free: releaseReq = 1'b1;
        heapPkg::write: begin
          storeWrite = 1'b1;
          newSize    = heapPkg::sizeT'(cmdQ.index) + 3'd1;
          sizeWrite  = newSize > arraySize;             // Grow only
        end
        heapPkg::push: begin
          storeWrite = 1'b1;
          sizeWrite  = 1'b1;
          newSize    = arraySize + 3'd1;
        end
        heapPkg::pop: begin
          sizeWrite = 1'b1;
          newSize   = arraySize - 3'd1;
        end
        default: ;
      endcase
    end
  end

  // One element per scan cycle
  always_comb begin
    accumNext = accum;
    if (inRange) begin
      case (cmdQ.opcode)
        heapPkg::index:        if (readData == cmdQ.data) accumNext = {1'b0, scanIdx} + 3'd1;
        heapPkg::countLess:    if (readData < cmdQ.data) accumNext = accum + 3'd1;
        heapPkg::countGreater: if (readData > cmdQ.data) accumNext = accum + 3'd1;
        default: ;
      endcase
    end
  end

  // ------------------------------
  // FSM
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state   <= heapPkg::idle;
      resultQ <= '0;
      errorQ  <= heapPkg::none;
      scanIdx <= '0;
      accum   <= '0;
    end else begin
      case (state)
        heapPkg::idle: if (start) state <= heapPkg::check;
        heapPkg::check: begin
          errorQ  <= checkError;
          scanIdx <= '0;
          accum   <= '0;
          state   <= heapPkg::finish;                   // Failed checks land here too
          if (checkError == heapPkg::none) begin
            case (cmdQ.opcode)
              heapPkg::alloc:              resultQ <= heapPkg::dataT'(nextArray);
              heapPkg::write:              resultQ <= cmdQ.data;
              heapPkg::read, heapPkg::pop: resultQ <= readData;
              heapPkg::size:               resultQ <= heapPkg::dataT'(arraySize);
              heapPkg::index, heapPkg::countLess, heapPkg::countGreater:
                state <= heapPkg::scan;
              default: ;
            endcase
          end
        end
        heapPkg::scan: begin
          accum   <= accumNext;
          scanIdx <= scanIdx + 1'b1;
          if (lastScan) begin
            resultQ <= heapPkg::dataT'(accumNext);
            state   <= heapPkg::finish;
          end
        end
        default: state <= heapPkg::idle;                // Finish
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start && !busy) cmdQ <= cmd;                    // Latch on entry to check
  end

endmodule

//--- hw/heapTop.sv
`timescale 1ns/1ps
//------------------------------
// Array heap behind an APB slave
// One command runs at a time, host polls status
//------------------------------
module heapTop (
  input  logic             clock,
  input  logic             resetN,
  input  heapPkg::apbReqT  apbReq,
  output heapPkg::apbRespT apbResp
);

  heapPkg::heapCmdT  cmd;                               // Command to sequencer
  heapPkg::heapRespT resp;                              // Result and error back
  logic              start;
  logic              busy;
  heapPkg::arrayIdT  storeArray;                        // Shared array address
  heapPkg::elemIdxT  storeIndex;
  logic              storeWrite;
  heapPkg::dataT     storeData;
  logic              sizeWrite;
  heapPkg::sizeT     newSize;
  logic              clearSizes;                        // Also clears allocator
  heapPkg::dataT     readData;
  heapPkg::sizeT     arraySize;
  logic              allocate;
  logic              releaseReq;
  logic              isAllocated;
  heapPkg::sizeT     highWater;
  logic              canAllocate;
  heapPkg::arrayIdT  nextArray;

  apbRegs regs (.clock, .resetN, .apbReq, .apbResp, .cmd, .start, .busy, .resp);

  heapSequencer sequencer (
    .clock, .resetN, .cmd, .start, .busy, .resp,
    .storeArray, .storeIndex, .storeWrite, .storeData,
    .sizeWrite, .newSize, .clearSizes, .readData, .arraySize,
    .allocate, .releaseReq, .isAllocated, .highWater, .canAllocate, .nextArray
  );

  arrayStore store (
    .clock, .resetN, .array(storeArray), .index(storeIndex),
    .write(storeWrite), .data(storeData), .sizeWrite, .newSize,
    .clearSizes, .readData, .arraySize
  );

  arrayAllocator allocator (
    .clock, .resetN, .allocate, .releaseReq, .clearAll(clearSizes),
    .array(storeArray), .isAllocated, .highWater, .canAllocate, .nextArray
  );

endmodule

//--- tests/heapTb.sv
`timescale 1ns/1ps
//------------------------------
// Drives heapTop over APB and checks it against a software model
// Stops at the first mismatch or timeout
//------------------------------
module heapTb;

  logic              clock;
  logic              resetN;
  heapPkg::apbReqT   apbReq;
  heapPkg::apbRespT  apbResp;

  logic [15:0]       lfsr;                               // Random source
  heapPkg::sizeT     modelSize  [heapPkg::arrayCount];   // Reference model
  logic              modelAlloc [heapPkg::arrayCount];
  heapPkg::dataT     modelMem   [heapPkg::arrayCount][heapPkg::arrayLength];
  int                modelHighWater;
  heapPkg::arrayIdT  modelFreed [$];                     // Freed stack with its top at the back

  heapTop dut (.clock, .resetN, .apbReq, .apbResp);

  initial clock = 1'b0;
  always #50 clock = ~clock;                             // 100 ns period

  // ------------------------------
  // Failure handling and random data
  task automatic abortRun();
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic expectEqual(input logic [31:0] got, input logic [31:0] want,
                             input string what);
    assert (got === want) else begin
      $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, want);
      abortRun();
    end
  endtask

  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    logic feedback;
    feedback = s[15] ^ s[13] ^ s[12] ^ s[10];            // Taps 16 14 13 11
    return {s[14:0], feedback};
  endfunction

  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr  = lfsrStep(lfsr);                            // One step per bit
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  // ------------------------------
  // APB master
  task automatic apbTransfer(input logic isWrite, input heapPkg::apbAddrT addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic slvErr, output int stalls);
    @(posedge clock);
    apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: isWrite, paddr: addr, pwdata: wdata};
    @(posedge clock);
    apbReq.penable <= 1'b1;                              // Access cycle
    stalls = 0;
    @(negedge clock);
    while (!apbResp.pready) begin
      stalls++;
      if (stalls > 50) begin
        $display("Timed out waiting for pready at offset 0x%02h", addr);
        abortRun();
      end else begin
        @(negedge clock);
      end
    end
    rdata  = apbResp.prdata;                             // Stable mid cycle
    slvErr = apbResp.pslverr;
    @(posedge clock);                                    // Completing edge
    apbReq <= '0;
  endtask

  task automatic writeReg(input heapPkg::apbAddrT addr, input logic [31:0] value);
    logic [31:0] ignored;
    logic        slvErr;
    int          stalls;
    apbTransfer(1'b1, addr, value, ignored, slvErr, stalls);
    expectEqual(slvErr, 0, "pslverr on write");
    expectEqual(stalls, 0, "wait states on write");
  endtask

  task automatic readReg(input heapPkg::apbAddrT addr, output logic [31:0] value);
    logic slvErr;
    int   stalls;
    apbTransfer(1'b0, addr, '0, value, slvErr, stalls);
    expectEqual(slvErr, 0, "pslverr on read");
    expectEqual(stalls, 0, "wait states on read");
  endtask

  // ------------------------------
  // Reference model of one command
  task automatic modelCommand(input heapPkg::opcodeT op, input heapPkg::arrayIdT arr,
                              input heapPkg::elemIdxT idx, input heapPkg::dataT value,
                              output heapPkg::dataT result, output heapPkg::errorT error,
                              output logic hasResult);
    logic             arrayOp;
    int               count;
    int               size;
    heapPkg::arrayIdT picked;
    arrayOp   = !(op inside {heapPkg::clear, heapPkg::alloc});
    hasResult = !(op inside {heapPkg::clear, heapPkg::free, heapPkg::push});
    result    = '0;
    error     = heapPkg::none;
    size      = modelSize[arr];
    if (arrayOp && int'(arr) >= modelHighWater) error = heapPkg::notAllocated;
    else if (arrayOp && !modelAlloc[arr]) error = heapPkg::freed;
    else if (op == heapPkg::alloc && modelFreed.size() == 0 &&
             modelHighWater == heapPkg::arrayCount) error = heapPkg::outOfMemory;
    else if (op == heapPkg::read && int'(idx) >= size) error = heapPkg::outOfBounds;
    else if (op == heapPkg::push && size == heapPkg::arrayLength) error = heapPkg::full;
    else if (op == heapPkg::pop && size == 0) error = heapPkg::empty;
    if (error != heapPkg::none) return;                  // No side effects
    case (op)
      heapPkg::clear: begin
        modelSize      = '{default: '0};
        modelAlloc     = '{default: 1'b0};
        modelHighWater = 0;
        modelFreed.delete();
      end
      heapPkg::alloc: begin
        if (modelFreed.size() > 0) begin
          picked = modelFreed.pop_back();                // Freed first
        end else begin
          picked = heapPkg::arrayIdT'(modelHighWater);
          modelHighWater++;
        end
        modelAlloc[picked] = 1'b1;
        modelSize[picked]  = '0;
        result             = heapPkg::dataT'(picked);
      end
      heapPkg::free: begin
        modelFreed.push_back(arr);
        modelAlloc[arr] = 1'b0;
      end
      heapPkg::write: begin
        modelMem[arr][idx] = value;
        if (int'(idx) + 1 > size) modelSize[arr] = heapPkg::sizeT'(int'(idx) + 1);
        result = value;
      end
      heapPkg::read: result = modelMem[arr][idx];
      heapPkg::size: result = heapPkg::dataT'(size);
      heapPkg::push: begin
        modelMem[arr][size] = value;
        modelSize[arr]      = heapPkg::sizeT'(size + 1);
      end
      heapPkg::pop: begin
        modelSize[arr] = heapPkg::sizeT'(size - 1);
        result         = modelMem[arr][size - 1];        // Element at the new size
      end
      default: begin                                     // Searches
        count = 0;
        for (int i = 0; i < size; i++) begin
          if (op == heapPkg::index && modelMem[arr][i] == value) count = i + 1;
          if (op == heapPkg::countLess && modelMem[arr][i] < value) count++;
          if (op == heapPkg::countGreater && modelMem[arr][i] > value) count++;
        end
        result = heapPkg::dataT'(count);
      end
    endcase
  endtask

  // ------------------------------
  // Command level tasks
  task automatic loadOperands(input heapPkg::arrayIdT arr, input heapPkg::elemIdxT idx,
                              input heapPkg::dataT value);
    writeReg(heapPkg::regArray, 32'(arr));
    writeReg(heapPkg::regIndex, 32'(idx));
    writeReg(heapPkg::regData, 32'(value));
  endtask

  task automatic finishCommand(output heapPkg::dataT result, output heapPkg::errorT error);
    logic [31:0] status;
    int          polls;
    polls = 0;
    readReg(heapPkg::regStatus, status);
    while (status[0]) begin                              // Busy bit
      polls++;
      if (polls > 50) begin
        $display("Timed out waiting for the command to finish");
        abortRun();
      end else begin
        readReg(heapPkg::regStatus, status);
      end
    end
    error = heapPkg::errorT'(status[6:4]);
    readReg(heapPkg::regResult, status);
    result = heapPkg::dataT'(status);
  endtask

  task automatic compareResponse(input heapPkg::dataT result, input heapPkg::errorT error,
                                 input heapPkg::dataT wantResult,
                                 input heapPkg::errorT wantError, input logic hasResult);
    expectEqual(32'(error), 32'(wantError), "error code");
    if (hasResult && wantError == heapPkg::none) begin
      expectEqual(32'(result), 32'(wantResult), "result");
    end
  endtask

  task automatic checkCommand(input heapPkg::opcodeT op, input heapPkg::arrayIdT arr,
                              input heapPkg::elemIdxT idx, input heapPkg::dataT value,
                              output heapPkg::dataT result, output heapPkg::errorT error);
    heapPkg::dataT  wantResult;
    heapPkg::errorT wantError;
    logic           hasResult;
    modelCommand(op, arr, idx, value, wantResult, wantError, hasResult);
    loadOperands(arr, idx, value);
    writeReg(heapPkg::regCommand, 32'(op));             // Starts the command
    finishCommand(result, error);
    compareResponse(result, error, wantResult, wantError, hasResult);
  endtask

  // ------------------------------
  // Test sequence
  initial begin
    heapPkg::dataT  result;
    heapPkg::errorT error;
    heapPkg::dataT  wantResult;
    heapPkg::errorT wantError;
    logic           hasResult;
    logic [31:0]    rdata;
    logic           slvErr;
    int             stalls;
    heapPkg::dataT  values [heapPkg::arrayLength];
    heapPkg::dataT  key;
    lfsr           = 16'd36664;
    modelSize      = '{default: '0};
    modelAlloc     = '{default: 1'b0};
    modelHighWater = 0;
    resetN <= 1'b0;
    apbReq <= '0;
    repeat (4) @(posedge clock);
    resetN <= 1'b1;

    readReg(heapPkg::regStatus, rdata);                  // Reset state
    expectEqual(rdata[0], 0, "busy after reset");
    expectEqual(rdata[6:4], heapPkg::none, "error after reset");
    apbTransfer(1'b0, 8'h18, '0, rdata, slvErr, stalls);
    expectEqual(slvErr, 1, "pslverr at unmapped offset");
    apbTransfer(1'b1, heapPkg::regResult, 32'd5, rdata, slvErr, stalls);
    expectEqual(slvErr, 1, "pslverr on read only write");
    readReg(heapPkg::regResult, rdata);                  // Dropped write leaves reset value
    expectEqual(rdata, 0, "result after reset");
    loadOperands(2'd3, 2'd2, 12'hA5C);                   // Operand registers read back
    readReg(heapPkg::regArray, rdata);
    expectEqual(rdata, 3, "array register");
    readReg(heapPkg::regIndex, rdata);
    expectEqual(rdata, 2, "index register");
    readReg(heapPkg::regData, rdata);
    expectEqual(rdata, 12'hA5C, "data register");

    for (int k = 0; k < heapPkg::arrayCount; k++) begin  // Fresh allocations
      checkCommand(heapPkg::alloc, '0, '0, '0, result, error);
      expectEqual(result, k, "allocated array");
    end
    checkCommand(heapPkg::alloc, '0, '0, '0, result, error);
    expectEqual(error, heapPkg::outOfMemory, "fifth alloc error");
    checkCommand(heapPkg::free, 2'd1, '0, '0, result, error);
    checkCommand(heapPkg::free, 2'd2, '0, '0, result, error);
    checkCommand(heapPkg::alloc, '0, '0, '0, result, error);
    expectEqual(result, 2, "reused array");
    checkCommand(heapPkg::alloc, '0, '0, '0, result, error);
    expectEqual(result, 1, "reused array");
    checkCommand(heapPkg::free, 2'd3, '0, '0, result, error);
    checkCommand(heapPkg::free, 2'd3, '0, '0, result, error);
    expectEqual(error, heapPkg::freed, "double free error");
    checkCommand(heapPkg::read, 2'd3, '0, '0, result, error);
    expectEqual(error, heapPkg::freed, "read of freed array error");
    checkCommand(heapPkg::clear, '0, '0, '0, result, error);
    checkCommand(heapPkg::size, 2'd0, '0, '0, result, error);
    expectEqual(error, heapPkg::notAllocated, "size above high water error");

    checkCommand(heapPkg::alloc, '0, '0, '0, result, error);  // Array 0 gets random data
    for (int i = 0; i < heapPkg::arrayLength; i++) begin
      values[i] = heapPkg::dataT'(randomBits(heapPkg::dataBits));
      checkCommand(heapPkg::write, 2'd0, heapPkg::elemIdxT'(i), values[i], result, error);
      checkCommand(heapPkg::size, 2'd0, '0, '0, result, error);
      expectEqual(result, i + 1, "size after write");
    end
    for (int i = 0; i < heapPkg::arrayLength; i++) begin
      checkCommand(heapPkg::read, 2'd0, heapPkg::elemIdxT'(i), '0, result, error);
      expectEqual(result, values[i], "read back");
    end
    checkCommand(heapPkg::alloc, '0, '0, '0, result, error);  // Array 1 for bounds checks
    checkCommand(heapPkg::read, 2'd1, 2'd0, '0, result, error);
    expectEqual(error, heapPkg::outOfBounds, "read of empty array error");
    checkCommand(heapPkg::write, 2'd1, 2'd1, 12'd77, result, error);
    checkCommand(heapPkg::read, 2'd1, 2'd2, '0, result, error);
    expectEqual(error, heapPkg::outOfBounds, "read past size error");
    checkCommand(heapPkg::write, 2'd1, 2'd0, 12'd55, result, error);  // Lower index keeps size
    checkCommand(heapPkg::size, 2'd1, '0, '0, result, error);
    expectEqual(result, 2, "size after lower write");

    checkCommand(heapPkg::alloc, '0, '0, '0, result, error);  // Array 2 used as a stack
    for (int i = 0; i < heapPkg::arrayLength; i++) begin
      values[i] = heapPkg::dataT'(randomBits(heapPkg::dataBits));
      checkCommand(heapPkg::push, 2'd2, '0, values[i], result, error);
    end
    checkCommand(heapPkg::push, 2'd2, '0, 12'd1, result, error);
    expectEqual(error, heapPkg::full, "push onto full array error");
    for (int i = heapPkg::arrayLength - 1; i >= 0; i--) begin
      checkCommand(heapPkg::pop, 2'd2, '0, '0, result, error);
      expectEqual(result, values[i], "popped value");
    end
    checkCommand(heapPkg::pop, 2'd2, '0, '0, result, error);
    expectEqual(error, heapPkg::empty, "pop of empty array error");

    checkCommand(heapPkg::alloc, '0, '0, '0, result, error);  // Array 3 holds 10 20 30
    for (int i = 1; i <= 3; i++) begin
      checkCommand(heapPkg::push, 2'd3, '0, heapPkg::dataT'(10 * i), result, error);
    end
    for (int k = 0; k < 4; k++) begin
      key = heapPkg::dataT'(k < 3 ? 30 - 10 * k : 15);
      checkCommand(heapPkg::index, 2'd3, '0, key, result, error);
      expectEqual(result, 3 - k, "Index result");
      key = heapPkg::dataT'(35 - 10 * k);
      checkCommand(heapPkg::countLess, 2'd3, '0, key, result, error);
      expectEqual(result, 3 - k, "CountLess result");
      checkCommand(heapPkg::countGreater, 2'd3, '0, key, result, error);
      expectEqual(result, k, "CountGreater result");
    end
    checkCommand(heapPkg::push, 2'd3, '0, 12'd10, result, error);  // 10 again at the end
    checkCommand(heapPkg::index, 2'd3, '0, 12'd10, result, error);
    expectEqual(result, 4, "Index of a repeated value");
    for (int k = 0; k <= heapPkg::arrayLength; k++) begin  // Random array 0
      if (k < heapPkg::arrayLength) key = modelMem[0][k];
      else key = heapPkg::dataT'(randomBits(heapPkg::dataBits));
      checkCommand(heapPkg::index, 2'd0, '0, key, result, error);
      checkCommand(heapPkg::countLess, 2'd0, '0, key, result, error);
      checkCommand(heapPkg::countGreater, 2'd0, '0, key, result, error);
    end

    key = modelMem[0][1];                                // Back-pressure
    modelCommand(heapPkg::countGreater, 2'd0, '0, key, wantResult, wantError, hasResult);
    loadOperands(2'd0, '0, key);
    writeReg(heapPkg::regCommand, 32'(heapPkg::index));
    apbTransfer(1'b1, heapPkg::regCommand, 32'(heapPkg::countGreater), rdata, slvErr, stalls);
    expectEqual(slvErr, 0, "pslverr on stalled command");
    expectEqual(stalls > 0, 1, "pready held low while busy");
    finishCommand(result, error);
    compareResponse(result, error, wantResult, wantError, hasResult);

    $display("Finished with no errors");
    $finish;
  end

endmodule
